// File: logic/tcdm_group_pkg.sv
//////////////////////////////////////////////////
// Word addresses only, there is no byte offset
// Address fields from MSB to LSB: group, tile, row
//////////////////////////////////////////////////

package tcdm_group_pkg;

  localparam int unsigned DATA_WIDTH     = 32;
  localparam int unsigned STRB_WIDTH     = DATA_WIDTH / 8;
  localparam int unsigned TILE_ID_WIDTH  = 2;
  localparam int unsigned ROW_WIDTH      = 8;
  localparam int unsigned GROUP_ID_WIDTH = 1;
  localparam int unsigned ADDR_WIDTH     = GROUP_ID_WIDTH + TILE_ID_WIDTH + ROW_WIDTH;

  // Field offsets within a word address
  localparam int unsigned ROW_LSB   = 0;
  localparam int unsigned TILE_LSB  = ROW_LSB + ROW_WIDTH;
  localparam int unsigned GROUP_LSB = TILE_LSB + TILE_ID_WIDTH;

  typedef logic [DATA_WIDTH-1:0]     data_t;
  typedef logic [STRB_WIDTH-1:0]     strb_t;
  typedef logic [TILE_ID_WIDTH-1:0]  tile_id_t;
  typedef logic [ROW_WIDTH-1:0]      row_t;
  typedef logic [GROUP_ID_WIDTH-1:0] group_id_t;
  typedef logic [ADDR_WIDTH-1:0]     tcdm_addr_t;

  typedef struct packed {
    tcdm_addr_t addr;
    logic       wen;
    data_t      wdata;
    strb_t      be;
  } core_req_t;

  typedef struct packed {
    tcdm_addr_t addr;
    logic       wen;
    data_t      wdata;
    strb_t      be;
    tile_id_t   ini;
  } tcdm_req_t;

  typedef struct packed {
    data_t    rdata;
    tile_id_t ini;
  } tcdm_resp_t;

  function automatic group_id_t addr_group(tcdm_addr_t addr);
    return addr[GROUP_LSB +: GROUP_ID_WIDTH];
  endfunction

  function automatic tile_id_t addr_tile(tcdm_addr_t addr);
    return addr[TILE_LSB +: TILE_ID_WIDTH];
  endfunction

  function automatic row_t addr_row(tcdm_addr_t addr);
    return addr[ROW_LSB +: ROW_WIDTH];
  endfunction

endpackage

// File: logic/tcdm_bank.sv
//////////////////////////////////////////////////
// BANK_ROWS is a power of two between 2 and 256
// Upper row bits beyond the bank depth are ignored
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tcdm_bank #(
  parameter int unsigned BANK_ROWS = 256
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  tcdm_group_pkg::tcdm_req_t  req_i,
  input  logic                       req_valid_i,
  output tcdm_group_pkg::tcdm_resp_t resp_o,
  output logic                       resp_valid_o
);
  import tcdm_group_pkg::*;

  localparam int unsigned IDX_WIDTH = $clog2(BANK_ROWS);

  data_t                mem [BANK_ROWS];
  logic [IDX_WIDTH-1:0] idx;

  assign idx = IDX_WIDTH'(addr_row(req_i.addr));

  // Byte-masked write
  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_i.wen) begin
      for (int unsigned b = 0; b < STRB_WIDTH; b++) begin
        if (req_i.be[b]) begin
          mem[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
        end
      end
    end
  end

  // Writes answer with zero data
  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      resp_o.rdata <= req_i.wen ? '0 : mem[idx];
      resp_o.ini   <= req_i.ini;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      resp_valid_o <= 1'b0;
    end else begin
      resp_valid_o <= req_valid_i;
    end
  end

endmodule

// File: logic/tile_router.sv
//////////////////////////////////////////////////
// One request in flight per core
// A new request may enter in the cycle of the response
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tile_router (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  tcdm_group_pkg::group_id_t  group_id_i,
  input  tcdm_group_pkg::tile_id_t   tile_id_i,
  // Core port
  input  tcdm_group_pkg::core_req_t  core_req_i,
  input  logic                       core_req_valid_i,
  output logic                       core_req_ready_o,
  output tcdm_group_pkg::tcdm_resp_t core_resp_o,
  output logic                       core_resp_valid_o,
  // Local path
  output tcdm_group_pkg::tcdm_req_t  local_req_o,
  output logic                       local_req_valid_o,
  input  logic                       local_req_ready_i,
  input  tcdm_group_pkg::data_t      local_resp_i,
  input  logic                       local_resp_valid_i,
  // Remote path
  output tcdm_group_pkg::tcdm_req_t  remote_req_o,
  output logic                       remote_req_valid_o,
  input  logic                       remote_req_ready_i,
  input  tcdm_group_pkg::tcdm_resp_t remote_resp_i,
  input  logic                       remote_resp_valid_i
);
  import tcdm_group_pkg::*;

  tcdm_req_t req;
  logic      is_local;
  logic      resp_valid;
  logic      can_issue;
  logic      pending_q;

  assign req = '{
    addr:  core_req_i.addr,
    wen:   core_req_i.wen,
    wdata: core_req_i.wdata,
    be:    core_req_i.be,
    ini:   tile_id_i
  };

  assign is_local   = (addr_group(core_req_i.addr) == group_id_i);
  assign resp_valid = local_resp_valid_i | remote_resp_valid_i;
  // Slot frees up as its response returns
  assign can_issue  = ~pending_q | resp_valid;

  assign local_req_o        = req;
  assign remote_req_o       = req;
  assign local_req_valid_o  = core_req_valid_i & can_issue & is_local;
  assign remote_req_valid_o = core_req_valid_i & can_issue & ~is_local;
  assign core_req_ready_o   = can_issue & (is_local ? local_req_ready_i : remote_req_ready_i);

  // Only one path can answer at a time
  always_comb begin
    if (remote_resp_valid_i) begin
      core_resp_o = remote_resp_i;
    end else begin
      core_resp_o.rdata = local_resp_i;
      core_resp_o.ini   = tile_id_i;
    end
  end

  assign core_resp_valid_o = resp_valid;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pending_q <= 1'b0;
    end else if (core_req_valid_i && core_req_ready_o) begin
      pending_q <= 1'b1;
    end else if (resp_valid) begin
      pending_q <= 1'b0;
    end
  end

endmodule

// File: logic/local_xbar.sv
//////////////////////////////////////////////////
// Requests must name a tile below NUM_TILES
// Each master keeps at most one request in flight
//////////////////////////////////////////////////

`timescale 1ns/1ps

module local_xbar #(
  parameter int unsigned NUM_TILES = 4
) (
  input  logic                                       clk_i,
  input  logic                                       rst_n_i,
  // Tile requesters
  input  tcdm_group_pkg::tcdm_req_t  [NUM_TILES-1:0] mst_req_i,
  input  logic                       [NUM_TILES-1:0] mst_req_valid_i,
  output logic                       [NUM_TILES-1:0] mst_req_ready_o,
  output tcdm_group_pkg::data_t      [NUM_TILES-1:0] mst_resp_o,
  output logic                       [NUM_TILES-1:0] mst_resp_valid_o,
  // Tile banks
  output tcdm_group_pkg::tcdm_req_t  [NUM_TILES-1:0] slv_req_o,
  output logic                       [NUM_TILES-1:0] slv_req_valid_o,
  input  logic                       [NUM_TILES-1:0] slv_req_ready_i,
  input  tcdm_group_pkg::tcdm_resp_t [NUM_TILES-1:0] slv_resp_i,
  input  logic                       [NUM_TILES-1:0] slv_resp_valid_i
);
  import tcdm_group_pkg::*;

  // hit[bank][master]
  logic     [NUM_TILES-1:0][NUM_TILES-1:0] hit;
  tile_id_t [NUM_TILES-1:0]                win;
  tile_id_t [NUM_TILES-1:0]                rr_q;

  always_comb begin
    for (int unsigned b = 0; b < NUM_TILES; b++) begin
      for (int unsigned m = 0; m < NUM_TILES; m++) begin
        hit[b][m] = mst_req_valid_i[m] && (addr_tile(mst_req_i[m].addr) == tile_id_t'(b));
      end
    end
  end

  // Round-robin pick, closest to the pointer wins
  always_comb begin
    int unsigned idx;
    win             = '0;
    slv_req_valid_o = '0;
    for (int unsigned b = 0; b < NUM_TILES; b++) begin
      for (int off = NUM_TILES - 1; off >= 0; off--) begin
        idx = (int'(rr_q[b]) + off) % NUM_TILES;
        if (hit[b][idx]) begin
          win[b]             = tile_id_t'(idx);
          slv_req_valid_o[b] = 1'b1;
        end
      end
    end
  end

  always_comb begin
    mst_req_ready_o = '0;
    for (int unsigned b = 0; b < NUM_TILES; b++) begin
      slv_req_o[b] = mst_req_i[win[b]];
      if (slv_req_valid_o[b]) begin
        mst_req_ready_o[win[b]] = slv_req_ready_i[b];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rr_q <= '0;
    end else begin
      for (int unsigned b = 0; b < NUM_TILES; b++) begin
        if (slv_req_valid_o[b] && slv_req_ready_i[b]) begin
          rr_q[b] <= tile_id_t'((int'(win[b]) + 1) % NUM_TILES);
        end
      end
    end
  end

  // Back to the initiator, one request in flight per master so no clash
  always_comb begin
    mst_resp_o       = '0;
    mst_resp_valid_o = '0;
    for (int unsigned b = 0; b < NUM_TILES; b++) begin
      if (slv_resp_valid_i[b]) begin
        mst_resp_o[slv_resp_i[b].ini]       = slv_resp_i[b].rdata;
        mst_resp_valid_o[slv_resp_i[b].ini] = 1'b1;
      end
    end
  end

endmodule

// File: logic/tcdm_tile.sv
//////////////////////////////////////////////////
// Local and remote slave traffic share one bank
// Priority alternates after every bank grant
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tcdm_tile #(
  parameter int unsigned BANK_ROWS = 256
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  tcdm_group_pkg::group_id_t  group_id_i,
  input  tcdm_group_pkg::tile_id_t   tile_id_i,
  // Core port
  input  tcdm_group_pkg::core_req_t  core_req_i,
  input  logic                       core_req_valid_i,
  output logic                       core_req_ready_o,
  output tcdm_group_pkg::tcdm_resp_t core_resp_o,
  output logic                       core_resp_valid_o,
  // Remote master port
  output tcdm_group_pkg::tcdm_req_t  remote_req_o,
  output logic                       remote_req_valid_o,
  input  logic                       remote_req_ready_i,
  input  tcdm_group_pkg::tcdm_resp_t remote_resp_i,
  input  logic                       remote_resp_valid_i,
  // Crossbar, requester side
  output tcdm_group_pkg::tcdm_req_t  xbar_mst_req_o,
  output logic                       xbar_mst_req_valid_o,
  input  logic                       xbar_mst_req_ready_i,
  input  tcdm_group_pkg::data_t      xbar_mst_resp_i,
  input  logic                       xbar_mst_resp_valid_i,
  // Crossbar, bank side
  input  tcdm_group_pkg::tcdm_req_t  xbar_slv_req_i,
  input  logic                       xbar_slv_req_valid_i,
  output logic                       xbar_slv_req_ready_o,
  output tcdm_group_pkg::tcdm_resp_t xbar_slv_resp_o,
  output logic                       xbar_slv_resp_valid_o,
  // Remote slave port
  input  tcdm_group_pkg::tcdm_req_t  remote_slv_req_i,
  input  logic                       remote_slv_req_valid_i,
  output logic                       remote_slv_req_ready_o,
  output tcdm_group_pkg::tcdm_resp_t remote_slv_resp_o,
  output logic                       remote_slv_resp_valid_o
);
  import tcdm_group_pkg::*;

  tcdm_req_t  bank_req;
  logic       bank_req_valid;
  tcdm_resp_t bank_resp;
  logic       bank_resp_valid;
  logic       local_gnt;
  logic       remote_gnt;
  logic       prio_remote_q;
  logic       src_remote_q;

  tile_router i_router (
    .clk_i              (clk_i                ),
    .rst_n_i            (rst_n_i              ),
    .group_id_i         (group_id_i           ),
    .tile_id_i          (tile_id_i            ),
    .core_req_i         (core_req_i           ),
    .core_req_valid_i   (core_req_valid_i     ),
    .core_req_ready_o   (core_req_ready_o     ),
    .core_resp_o        (core_resp_o          ),
    .core_resp_valid_o  (core_resp_valid_o    ),
    .local_req_o        (xbar_mst_req_o       ),
    .local_req_valid_o  (xbar_mst_req_valid_o ),
    .local_req_ready_i  (xbar_mst_req_ready_i ),
    .local_resp_i       (xbar_mst_resp_i      ),
    .local_resp_valid_i (xbar_mst_resp_valid_i),
    .remote_req_o       (remote_req_o         ),
    .remote_req_valid_o (remote_req_valid_o   ),
    .remote_req_ready_i (remote_req_ready_i   ),
    .remote_resp_i      (remote_resp_i        ),
    .remote_resp_valid_i(remote_resp_valid_i  )
  );

  assign local_gnt  = xbar_slv_req_valid_i & (~remote_slv_req_valid_i | ~prio_remote_q);
  assign remote_gnt = remote_slv_req_valid_i & (~xbar_slv_req_valid_i | prio_remote_q);

  assign xbar_slv_req_ready_o   = ~remote_slv_req_valid_i | ~prio_remote_q;
  assign remote_slv_req_ready_o = ~xbar_slv_req_valid_i | prio_remote_q;

  assign bank_req       = remote_gnt ? remote_slv_req_i : xbar_slv_req_i;
  assign bank_req_valid = local_gnt | remote_gnt;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      prio_remote_q <= 1'b0;
      src_remote_q  <= 1'b0;
    end else if (bank_req_valid) begin
      // The side just served yields next time
      prio_remote_q <= local_gnt;
      src_remote_q  <= remote_gnt;
    end
  end

  tcdm_bank #(
    .BANK_ROWS(BANK_ROWS)
  ) i_bank (
    .clk_i       (clk_i          ),
    .rst_n_i     (rst_n_i        ),
    .req_i       (bank_req       ),
    .req_valid_i (bank_req_valid ),
    .resp_o      (bank_resp      ),
    .resp_valid_o(bank_resp_valid)
  );

  assign xbar_slv_resp_o         = bank_resp;
  assign remote_slv_resp_o       = bank_resp;
  assign xbar_slv_resp_valid_o   = bank_resp_valid & ~src_remote_q;
  assign remote_slv_resp_valid_o = bank_resp_valid & src_remote_q;

endmodule

// File: logic/tcdm_group.sv
//////////////////////////////////////////////////
// Two groups in total, one remote port pair per tile
// NUM_TILES is 1, 2 or 4
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tcdm_group #(
  parameter int unsigned NUM_TILES = 4,
  parameter int unsigned BANK_ROWS = 256
) (
  input  logic                                       clk_i,
  input  logic                                       rst_n_i,
  input  tcdm_group_pkg::group_id_t                  group_id_i,
  // Core ports
  input  tcdm_group_pkg::core_req_t  [NUM_TILES-1:0] core_req_i,
  input  logic                       [NUM_TILES-1:0] core_req_valid_i,
  output logic                       [NUM_TILES-1:0] core_req_ready_o,
  output tcdm_group_pkg::tcdm_resp_t [NUM_TILES-1:0] core_resp_o,
  output logic                       [NUM_TILES-1:0] core_resp_valid_o,
  // Remote master ports
  output tcdm_group_pkg::tcdm_req_t  [NUM_TILES-1:0] remote_req_o,
  output logic                       [NUM_TILES-1:0] remote_req_valid_o,
  input  logic                       [NUM_TILES-1:0] remote_req_ready_i,
  input  tcdm_group_pkg::tcdm_resp_t [NUM_TILES-1:0] remote_resp_i,
  input  logic                       [NUM_TILES-1:0] remote_resp_valid_i,
  // Remote slave ports
  input  tcdm_group_pkg::tcdm_req_t  [NUM_TILES-1:0] remote_slv_req_i,
  input  logic                       [NUM_TILES-1:0] remote_slv_req_valid_i,
  output logic                       [NUM_TILES-1:0] remote_slv_req_ready_o,
  output tcdm_group_pkg::tcdm_resp_t [NUM_TILES-1:0] remote_slv_resp_o,
  output logic                       [NUM_TILES-1:0] remote_slv_resp_valid_o
);
  import tcdm_group_pkg::*;

  tcdm_req_t  [NUM_TILES-1:0] mst_req;
  logic       [NUM_TILES-1:0] mst_req_valid;
  logic       [NUM_TILES-1:0] mst_req_ready;
  data_t      [NUM_TILES-1:0] mst_resp;
  logic       [NUM_TILES-1:0] mst_resp_valid;
  tcdm_req_t  [NUM_TILES-1:0] slv_req;
  logic       [NUM_TILES-1:0] slv_req_valid;
  logic       [NUM_TILES-1:0] slv_req_ready;
  tcdm_resp_t [NUM_TILES-1:0] slv_resp;
  logic       [NUM_TILES-1:0] slv_resp_valid;

  for (genvar t = 0; t < NUM_TILES; t++) begin : gen_tiles
    tcdm_tile #(
      .BANK_ROWS(BANK_ROWS)
    ) i_tile (
      .clk_i                  (clk_i                     ),
      .rst_n_i                (rst_n_i                   ),
      .group_id_i             (group_id_i                ),
      .tile_id_i              (tile_id_t'(t)             ),
      .core_req_i             (core_req_i[t]             ),
      .core_req_valid_i       (core_req_valid_i[t]       ),
      .core_req_ready_o       (core_req_ready_o[t]       ),
      .core_resp_o            (core_resp_o[t]            ),
      .core_resp_valid_o      (core_resp_valid_o[t]      ),
      .remote_req_o           (remote_req_o[t]           ),
      .remote_req_valid_o     (remote_req_valid_o[t]     ),
      .remote_req_ready_i     (remote_req_ready_i[t]     ),
      .remote_resp_i          (remote_resp_i[t]          ),
      .remote_resp_valid_i    (remote_resp_valid_i[t]    ),
      .xbar_mst_req_o         (mst_req[t]                ),
      .xbar_mst_req_valid_o   (mst_req_valid[t]          ),
      .xbar_mst_req_ready_i   (mst_req_ready[t]          ),
      .xbar_mst_resp_i        (mst_resp[t]               ),
      .xbar_mst_resp_valid_i  (mst_resp_valid[t]         ),
      .xbar_slv_req_i         (slv_req[t]                ),
      .xbar_slv_req_valid_i   (slv_req_valid[t]          ),
      .xbar_slv_req_ready_o   (slv_req_ready[t]          ),
      .xbar_slv_resp_o        (slv_resp[t]               ),
      .xbar_slv_resp_valid_o  (slv_resp_valid[t]         ),
      .remote_slv_req_i       (remote_slv_req_i[t]       ),
      .remote_slv_req_valid_i (remote_slv_req_valid_i[t] ),
      .remote_slv_req_ready_o (remote_slv_req_ready_o[t] ),
      .remote_slv_resp_o      (remote_slv_resp_o[t]      ),
      .remote_slv_resp_valid_o(remote_slv_resp_valid_o[t])
    );
  end : gen_tiles

  local_xbar #(
    .NUM_TILES(NUM_TILES)
  ) i_local_xbar (
    .clk_i           (clk_i         ),
    .rst_n_i         (rst_n_i       ),
    .mst_req_i       (mst_req       ),
    .mst_req_valid_i (mst_req_valid ),
    .mst_req_ready_o (mst_req_ready ),
    .mst_resp_o      (mst_resp      ),
    .mst_resp_valid_o(mst_resp_valid),
    .slv_req_o       (slv_req       ),
    .slv_req_valid_o (slv_req_valid ),
    .slv_req_ready_i (slv_req_ready ),
    .slv_resp_i      (slv_resp      ),
    .slv_resp_valid_i(slv_resp_valid)
  );

endmodule

// File: verification/tcdm_group_asserts.sv
//////////////////////////////////////////////////
// Bound to tcdm_group, protocol checks only
// Data values are checked in the testbench
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tcdm_group_asserts #(
  parameter int unsigned NUM_TILES = 4
) (
  input logic                                      clk_i,
  input logic                                      rst_n_i,
  input logic                      [NUM_TILES-1:0] core_req_valid_i,
  input logic                      [NUM_TILES-1:0] core_req_ready_o,
  input logic                      [NUM_TILES-1:0] core_resp_valid_o,
  input tcdm_group_pkg::tcdm_req_t [NUM_TILES-1:0] remote_req_o,
  input logic                      [NUM_TILES-1:0] remote_req_valid_o,
  input logic                      [NUM_TILES-1:0] remote_req_ready_i,
  input logic                      [NUM_TILES-1:0] remote_slv_resp_valid_o
);

  int unsigned          fail_cnt = 0;
  logic [NUM_TILES-1:0] pend_q;

  // Shadow of the router's pending flag
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pend_q <= '0;
    end else begin
      for (int t = 0; t < NUM_TILES; t++) begin
        if (core_req_valid_i[t] && core_req_ready_o[t]) begin
          pend_q[t] <= 1'b1;
        end else if (core_resp_valid_o[t]) begin
          pend_q[t] <= 1'b0;
        end
      end
    end
  end

  reset_quiet: assert property (@(posedge clk_i)
      !rst_n_i |-> !(|{core_resp_valid_o, remote_req_valid_o, remote_slv_resp_valid_o}))
    else begin
      $error("valid output high during reset");
      fail_cnt++;
    end

  for (genvar t = 0; t < NUM_TILES; t++) begin : gen_tile_chk
    resp_when_pending: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        core_resp_valid_o[t] |-> pend_q[t])
      else begin
        $error("core response on tile %0d without a pending request", t);
        fail_cnt++;
      end

    ready_low_pending: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        pend_q[t] && !core_resp_valid_o[t] |-> !core_req_ready_o[t])
      else begin
        $error("core ready high on tile %0d while a request is pending", t);
        fail_cnt++;
      end

    remote_req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        remote_req_valid_o[t] && !remote_req_ready_i[t]
        |=> remote_req_valid_o[t] && $stable(remote_req_o[t]))
      else begin
        $error("remote request on tile %0d changed while waiting", t);
        fail_cnt++;
      end
  end : gen_tile_chk

endmodule

// File: verification/tb_tcdm_group.sv
//////////////////////////////////////////////////
// Group 0 under test, the model plays group 1
// Bank contents are only read after a full write
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_tcdm_group;
  import tcdm_group_pkg::*;

  localparam int NT = 4;
  localparam int ROWS = 256;
  localparam group_id_t GROUP = 1'b0;
  localparam int N_LOCAL = 12;
  localparam int N_REMOTE = 8;
  localparam int N_SLAVE = 6;
  localparam int N_ROUNDS = 4;
  localparam int N_BURST = 3;
  // Test lengths in cycles, about four cycles per access
  localparam int LEN_IDLE = 10;
  localparam int LEN_LOCAL = N_LOCAL * 3 * 4;
  localparam int LEN_REMOTE = N_REMOTE * 8;
  localparam int LEN_SLAVE = N_SLAVE * 3 * 4;
  localparam int LEN_CONT = N_ROUNDS * (NT * N_BURST + 1) * 4;
  localparam int WATCHDOG_CYCLES = (LEN_IDLE + LEN_LOCAL + LEN_REMOTE + LEN_SLAVE + LEN_CONT) * 4;

  logic clk_i, rst_n_i, started;
  group_id_t group_id_i;
  core_req_t [NT-1:0] core_req_i;
  logic [NT-1:0] core_req_valid_i, core_req_ready_o, core_resp_valid_o;
  tcdm_resp_t [NT-1:0] core_resp_o, remote_resp_i, remote_slv_resp_o;
  tcdm_req_t [NT-1:0] remote_req_o, remote_slv_req_i;
  logic [NT-1:0] remote_req_valid_o, remote_req_ready_i, remote_resp_valid_i;
  logic [NT-1:0] remote_slv_req_valid_i, remote_slv_req_ready_o, remote_slv_resp_valid_o;

  data_t ref_mem [NT*ROWS];
  data_t far_mem [NT*ROWS];
  data_t exp_core [NT];
  tcdm_resp_t exp_slv [NT];
  data_t far_rdata [NT];
  tile_id_t far_ini [NT];
  int far_delay [NT];
  logic [NT-1:0] far_pend;
  int core_wait [NT];
  int slv_wait [NT];
  int err_cnt = 0;
  int test_cnt = 0;
  int req_cnt = 0;
  int resp_cnt = 0;

  tcdm_group #(.NUM_TILES(NT), .BANK_ROWS(ROWS)) i_dut (.*);

  bind tcdm_group tcdm_group_asserts #(.NUM_TILES(NUM_TILES)) i_asserts (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles, a request never completed", WATCHDOG_CYCLES);
    $display("Finished with errors");
    $finish;
  end

  function automatic int mem_index(tcdm_addr_t a);
    return int'(a[TILE_LSB +: TILE_ID_WIDTH]) * ROWS + int'(a[ROW_WIDTH-1:0]);
  endfunction

  function automatic data_t merge(data_t old, data_t wdata, strb_t be);
    data_t res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) res[8*b +: 8] = wdata[8*b +: 8];
    end
    return res;
  endfunction

  // Reference memory, remote model and wait counters, sampled mid-cycle
  always @(negedge clk_i) begin
    int idx;
    for (int t = 0; t < NT; t++) begin
      if (core_resp_valid_o[t]) resp_cnt++;
      if (remote_slv_resp_valid_o[t]) resp_cnt++;
      if (core_req_valid_i[t] && core_req_ready_o[t]) begin
        req_cnt++;
        core_wait[t] = 0;
        idx = mem_index(core_req_i[t].addr);
        if (core_req_i[t].addr[GROUP_LSB] == GROUP) begin
          exp_core[t] = core_req_i[t].wen ? '0 : ref_mem[idx];
          if (core_req_i[t].wen)
            ref_mem[idx] = merge(ref_mem[idx], core_req_i[t].wdata, core_req_i[t].be);
        end
      end else if (core_req_valid_i[t] && core_req_i[t].addr[GROUP_LSB] == GROUP) begin
        core_wait[t]++;
      end
      if (remote_req_valid_o[t] && remote_req_ready_i[t]) begin
        idx = mem_index(remote_req_o[t].addr);
        far_rdata[t] = remote_req_o[t].wen ? '0 : far_mem[idx];
        exp_core[t] = far_rdata[t];
        far_ini[t] = remote_req_o[t].ini;
        if (remote_req_o[t].wen)
          far_mem[idx] = merge(far_mem[idx], remote_req_o[t].wdata, remote_req_o[t].be);
        far_delay[t] = int'($urandom_range(3, 0));
        far_pend[t] = 1'b1;
      end
      if (remote_slv_req_valid_i[t] && remote_slv_req_ready_o[t]) begin
        req_cnt++;
        slv_wait[t] = 0;
        idx = t * ROWS + int'(remote_slv_req_i[t].addr[ROW_WIDTH-1:0]);
        exp_slv[t].rdata = remote_slv_req_i[t].wen ? '0 : ref_mem[idx];
        exp_slv[t].ini = remote_slv_req_i[t].ini;
        if (remote_slv_req_i[t].wen)
          ref_mem[idx] = merge(ref_mem[idx], remote_slv_req_i[t].wdata, remote_slv_req_i[t].be);
      end else if (remote_slv_req_valid_i[t]) begin
        slv_wait[t]++;
      end
    end
  end

  // Remote group: random ready, answers after a random delay
  always @(posedge clk_i) begin
    #1;
    for (int t = 0; t < NT; t++) begin
      remote_req_ready_i[t] = ($urandom_range(3, 0) != 0);
      remote_resp_valid_i[t] = 1'b0;
      if (far_pend[t]) begin
        if (far_delay[t] == 0) begin
          remote_resp_i[t] = '{rdata: far_rdata[t], ini: far_ini[t]};
          remote_resp_valid_i[t] = 1'b1;
          far_pend[t] = 1'b0;
        end else begin
          far_delay[t]--;
        end
      end
    end
  end

  idle_chk: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !started |-> !(|{core_resp_valid_o, remote_req_valid_o, remote_slv_resp_valid_o}))
    else begin
      $display("A valid output went high before the first request");
      err_cnt++;
    end

  for (genvar t = 0; t < NT; t++) begin : gen_checks
    core_data_chk: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        core_resp_valid_o[t] |-> core_resp_o[t] == {exp_core[t], tile_id_t'(t)})
      else begin
        $display("[FAIL] core_resp_o[%0d] = %h, expected %h", t,
                 $sampled(core_resp_o[t]), {$sampled(exp_core[t]), tile_id_t'(t)});
        err_cnt++;
      end
    slv_data_chk: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        remote_slv_resp_valid_o[t] |-> remote_slv_resp_o[t] == exp_slv[t])
      else begin
        $display("[FAIL] remote_slv_resp_o[%0d] = %h, expected %h", t,
                 $sampled(remote_slv_resp_o[t]), $sampled(exp_slv[t]));
        err_cnt++;
      end
    remote_req_chk: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        remote_req_valid_o[t] |-> remote_req_o[t] == {core_req_i[t], tile_id_t'(t)})
      else begin
        $display("[FAIL] remote_req_o[%0d] = %h, expected %h", t,
                 $sampled(remote_req_o[t]), {$sampled(core_req_i[t]), tile_id_t'(t)});
        err_cnt++;
      end
    wait_chk: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        core_wait[t] <= NT + 1 && slv_wait[t] <= NT + 1)
      else begin
        $display("Requester on tile %0d waited too many grants", t);
        err_cnt++;
      end
  end : gen_checks

  // Called and returns at 1 ns after a rising edge
  task automatic core_access(input int t, input tcdm_addr_t addr, input logic wen,
                             input data_t wdata, input strb_t be);
    core_req_i[t] = '{addr: addr, wen: wen, wdata: wdata, be: be};
    core_req_valid_i[t] = 1'b1;
    @(negedge clk_i);
    while (!core_req_ready_o[t]) @(negedge clk_i);
    @(posedge clk_i);
    #1;
    core_req_valid_i[t] = 1'b0;
    @(negedge clk_i);
    while (!core_resp_valid_o[t]) @(negedge clk_i);
    @(posedge clk_i);
    #1;
  endtask

  task automatic slave_access(input int t, input tcdm_req_t req);
    remote_slv_req_i[t] = req;
    remote_slv_req_valid_i[t] = 1'b1;
    @(negedge clk_i);
    while (!remote_slv_req_ready_o[t]) @(negedge clk_i);
    @(posedge clk_i);
    #1;
    remote_slv_req_valid_i[t] = 1'b0;
    @(negedge clk_i);
    while (!remote_slv_resp_valid_o[t]) @(negedge clk_i);
    @(posedge clk_i);
    #1;
  endtask

  task automatic tile_test(input int which, input int t);
    tcdm_addr_t addr;
    for (int i = 0; i < N_LOCAL; i++) begin
      if (which == 1 && i < N_REMOTE) begin
        addr = {~GROUP, tile_id_t'($urandom_range(NT - 1, 0)), row_t'($urandom)};
        core_access(t, addr, 1'($urandom), $urandom, strb_t'($urandom));
      end else if (which == 0) begin
        addr = {GROUP, tile_id_t'($urandom_range(NT - 1, 0)), row_t'($urandom)};
        core_access(t, addr, 1'b1, $urandom, 4'hf);
        core_access(t, addr, 1'b1, $urandom, strb_t'($urandom));
        core_access(t, addr, 1'b0, '0, '0);
      end else if (which == 2 && i < N_SLAVE) begin
        addr = {GROUP, tile_id_t'(t), row_t'($urandom)};
        slave_access(t, '{addr: addr, wen: 1'b1, wdata: $urandom, be: 4'hf,
                          ini: tile_id_t'($urandom)});
        slave_access(t, '{addr: addr, wen: 1'b1, wdata: $urandom, be: strb_t'($urandom),
                          ini: tile_id_t'($urandom)});
        slave_access(t, '{addr: addr, wen: 1'b0, wdata: '0, be: '0,
                          ini: tile_id_t'($urandom)});
      end
    end
  endtask

  task automatic run_tiles(input int which);
    for (int t = 0; t < NT; t++) begin
      automatic int tt = t;
      fork
        tile_test(which, tt);
      join_none
    end
    wait fork;
  endtask

  // Back-to-back accesses to consecutive rows of bank 1
  task automatic burst_access(input int t, input int row, input logic wen);
    for (int j = 0; j < N_BURST; j++) begin
      core_access(t, {GROUP, 2'd1, row_t'(row + j)}, wen, $urandom, 4'hf);
    end
  endtask

  // All cores and the remote slave side hit bank 1 together
  task automatic contention_test();
    for (int r = 0; r < N_ROUNDS; r++) begin
      automatic logic wen = (r % 2 == 0);
      automatic int base = 8'h80 + 16 * (r / 2);
      for (int k = 0; k < NT; k++) begin
        automatic int kk = k;
        fork
          burst_access(kk, base + N_BURST * kk, wen);
        join_none
      end
      fork
        slave_access(1, '{addr: {GROUP, 2'd1, row_t'(base + NT * N_BURST)}, wen: wen,
                          wdata: $urandom, be: 4'hf, ini: tile_id_t'($urandom)});
      join_none
      wait fork;
    end
  endtask

  task automatic report(input string name);
    count_chk: assert (resp_cnt == req_cnt)
      else begin
        $display("[FAIL] response count = %h, expected %h", resp_cnt, req_cnt);
        err_cnt++;
      end
    test_cnt++;
    $display("Test %0d %s done, errors so far %0d", test_cnt, name, err_cnt);
  endtask

  initial begin
    int total;
    void'($urandom(32'hca5f));
    rst_n_i = 1'b0;
    started = 1'b0;
    group_id_i = GROUP;
    core_req_i = '0;
    core_req_valid_i = '0;
    remote_req_ready_i = '0;
    remote_resp_i = '0;
    remote_resp_valid_i = '0;
    remote_slv_req_i = '0;
    remote_slv_req_valid_i = '0;
    far_pend = '0;
    for (int i = 0; i < NT; i++) begin
      core_wait[i] = 0;
      slv_wait[i] = 0;
    end
    for (int i = 0; i < NT * ROWS; i++) far_mem[i] = 32'(i) * 32'h9e3779b1 ^ 32'h5a5a0000;
    repeat (2) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    repeat (LEN_IDLE) @(posedge clk_i);
    #1;
    report("idle after reset");
    started = 1'b1;
    run_tiles(0);
    report("local write and read");
    run_tiles(1);
    report("remote path");
    run_tiles(2);
    report("remote slave access");
    contention_test();
    report("bank contention");
    total = err_cnt + int'(i_dut.i_asserts.fail_cnt);
    $display("Tests run %0d, errors %0d", test_cnt, total);
    if (total == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: build.f
logic/tcdm_group_pkg.sv
logic/tcdm_bank.sv
logic/tile_router.sv
logic/local_xbar.sv
logic/tcdm_tile.sv
logic/tcdm_group.sv
verification/tcdm_group_asserts.sv
verification/tb_tcdm_group.sv

// File: Makefile
# Verilator simulation of the TCDM group

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -j 0 \
		--top-module tb_tcdm_group -Mdir obj_dir -f build.f
	./obj_dir/Vtb_tcdm_group +verilator+error+limit+1000 2>&1 | tee $(LOG)
	@if grep -q "Finished with errors" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "Finished with no errors" $(LOG); then echo "FAIL"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf obj_dir $(LOG)
